/* sim.f */
rtl/mc_pkg.sv
rtl/mc_wr_fifo.sv
rtl/mc_bank_table.sv
rtl/mc_refresh_timer.sv
rtl/mc_rd_path.sv
rtl/mc_wr_path.sv
rtl/mc_ctrl.sv
rtl/mc_top.sv
verification/tb_mc_top.sv

/* run_sim.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal --top-module tb_mc_top \
  -f sim.f -o tb_mc_top

out=$(./obj_dir/tb_mc_top)
printf '%s\n' "$out"

# the run passes only if the pass line was printed
printf '%s\n' "$out" | grep -q '^\*\* PASS \*\*$'

/* verification/tb_mc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mc_top import mc_pkg::*; ();

  localparam int N_REQ        = 16;
  localparam int ACCEPT_LIMIT = 200;
  localparam int ACK_LIMIT    = 50;
  localparam int REF_LIMIT    = REF_INTERVAL_C + T_RFC + 20;
  localparam int WATCHDOG_CYC = N_REQ * 200 + 2 * REF_INTERVAL_C;
  localparam int COL_W        = $bits(col_t);

  logic      clk_i;
  logic      rst_n_i;
  logic      mem_rd_i;
  logic      mem_wr_i;
  mem_addr_t mem_addr_i;
  mem_data_t mem_wrdata_i;
  mem_data_t mem_rddata_o;
  logic      mem_accept_o;
  logic      mem_ack_o;
  logic      dfi_cs_n_o;
  logic      dfi_ras_n_o;
  logic      dfi_cas_n_o;
  logic      dfi_we_n_o;
  bank_t     dfi_bank_o;
  row_t      dfi_address_o;
  logic      dfi_wrdata_en_o;
  dfi_data_t dfi_wrdata_o;
  logic      dfi_rddata_en_o;
  logic      dfi_rddata_valid_i;
  dfi_data_t dfi_rddata_i;
  logic      dfi_init_complete_i;

  mc_top u_dut (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  int unsigned cycle = 0;
  always @(posedge clk_i) cycle <= cycle + 1;

  int unsigned cmd_errs = 0;
  int unsigned data_errs = 0;
  int unsigned beat_errs = 0;
  int unsigned gap_errs = 0;
  int unsigned proto_errs = 0;
  int unsigned timeout_errs = 0;

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_cmd(input string what, input cmd_t got, input bank_t got_bank,
                           input row_t got_addr, input cmd_t exp, input bank_t exp_bank,
                           input row_t exp_addr, input row_t mask);
    if (got !== exp || got_bank !== exp_bank || ((got_addr ^ exp_addr) & mask) != '0) begin
      cmd_errs++;
      $display("[ERROR] %0t: %s: got %s bank %0d addr 0x%04h, expected %s bank %0d addr 0x%04h",
               $time, what, got.name(), got_bank, got_addr, exp.name(), exp_bank,
               exp_addr & mask);
    end
  endtask

  task automatic check_data(input string what, input mem_data_t got, input mem_data_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("[ERROR] %0t: %s: got 0x%032h, expected 0x%032h", $time, what, got, exp);
    end
  endtask

  task automatic check_beat(input string what, input dfi_data_t got, input dfi_data_t exp);
    if (got !== exp) begin
      beat_errs++;
      $display("[ERROR] %0t: %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_gap(input string what, input int unsigned got,
                           input int unsigned lo, input int unsigned hi);
    if (got < lo || got > hi) begin
      gap_errs++;
      $display("[ERROR] %0t: %s: %0d cycles, allowed %0d to %0d", $time, what, got, lo, hi);
    end
  endtask

  task automatic protocol_error(input string msg);
    proto_errs++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  logic        tab_wr   [N_REQ];
  row_t        tab_row  [N_REQ];
  bank_t       tab_bank [N_REQ];
  col_t        tab_col  [N_REQ];
  int          tab_src  [N_REQ];
  mem_data_t   tab_data [N_REQ];
  logic [31:0] rng_state = 32'h556c;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic mem_addr_t make_addr(input row_t row, input bank_t bank, input col_t col);
    return {row, bank, col};
  endfunction

  // src is the write entry whose word a read must return
  task automatic set_entry(input int idx, input logic wr, input row_t row, input bank_t bank,
                           input col_t col, input int src);
    tab_wr[idx]   = wr;
    tab_row[idx]  = row;
    tab_bank[idx] = bank;
    tab_col[idx]  = col;
    tab_src[idx]  = src;
    for (int k = 0; k < BEATS; k++) begin
      rng_state = xorshift32(rng_state);
      tab_data[idx][32*k +: 32] = rng_state;
    end
  endtask

  task automatic build_table();
    set_entry(0,  1'b1, 15'd5,      3'd0, 10'h010, -1);
    set_entry(1,  1'b1, 15'd5,      3'd0, 10'h018, -1);
    set_entry(2,  1'b0, 15'd5,      3'd0, 10'h010, 0);
    set_entry(3,  1'b0, 15'd5,      3'd0, 10'h018, 1);
    set_entry(4,  1'b1, 15'd9,      3'd0, 10'h020, -1);
    set_entry(5,  1'b0, 15'd9,      3'd0, 10'h020, 4);
    set_entry(6,  1'b0, 15'd5,      3'd0, 10'h010, 0);
    set_entry(7,  1'b1, 15'h7abc,   3'd7, 10'h3f8, -1);
    set_entry(8,  1'b1, 15'h1234,   3'd3, 10'h100, -1);
    set_entry(9,  1'b0, 15'h7abc,   3'd7, 10'h3f8, 7);
    set_entry(10, 1'b1, 15'h1234,   3'd3, 10'h100, -1);
    set_entry(11, 1'b0, 15'h1234,   3'd3, 10'h100, 10);
    set_entry(12, 1'b0, 15'h7abc,   3'd7, 10'h3f8, 7);
    set_entry(13, 1'b1, 15'd2,      3'd5, 10'h008, -1);
    set_entry(14, 1'b0, 15'd2,      3'd5, 10'h008, 13);
    set_entry(15, 1'b0, 15'd9,      3'd0, 10'h020, 4);
  endtask

  // ----------------------------------------
  // DFI model
  // ----------------------------------------
  logic        mdl_open [N_BANKS];
  row_t        mdl_row  [N_BANKS];
  logic        sb_open  [N_BANKS];
  row_t        sb_row   [N_BANKS];
  dfi_data_t   dram [int unsigned];
  dfi_data_t   rd_beats_q [$];
  int unsigned rd_cycle_q [$];
  int unsigned wr_key_q [$];
  mem_data_t   exp_wr_q [$];
  logic        valid_next = 1'b0;
  dfi_data_t   data_next = '0;
  int unsigned wr_beat = 0;
  bit          have_last = 1'b0;
  cmd_t        last_cmd = CMD_NOP;
  cmd_t        last_rw = CMD_NOP;
  int unsigned last_cmd_cycle = 0;
  int unsigned last_gap = 0;
  int unsigned ref_count = 0;
  int unsigned preall_count = 0;
  int unsigned last_ref_cycle = 0;
  bit          req_active = 1'b0;
  cmd_t        log_cmd [$];
  bank_t       log_bank [$];
  row_t        log_addr [$];

  function automatic int unsigned beat_key(input bank_t bank, input row_t row, input col_t col);
    return {bank, row, col[COL_W-1:3], 2'b00};
  endfunction

  function automatic dfi_data_t fill_word(input int unsigned key);
    return (key * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  always @(negedge clk_i) begin
    cmd_t        cmd;
    int unsigned key;
    mem_data_t   exp_word;
    cmd = cmd_t'({dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o});

    // read beats follow each enable cycle by one cycle
    dfi_rddata_valid_i = valid_next;
    dfi_rddata_i       = data_next;
    valid_next         = 1'b0;
    if (dfi_rddata_en_o) begin
      if (rd_beats_q.size() == 0) begin
        protocol_error("read enable without a READ");
      end else begin
        data_next  = rd_beats_q.pop_front();
        valid_next = 1'b1;
      end
    end

    if (dfi_wrdata_en_o) begin
      if (wr_key_q.size() == 0 || exp_wr_q.size() == 0) begin
        protocol_error("write enable without a WRITE");
      end else begin
        exp_word = exp_wr_q[0];
        check_beat($sformatf("write beat %0d", wr_beat), dfi_wrdata_o,
                   exp_word[32*wr_beat +: 32]);
        dram[wr_key_q[0] + wr_beat] = dfi_wrdata_o;
        wr_beat++;
        if (wr_beat == BEATS) begin
          wr_beat = 0;
          void'(wr_key_q.pop_front());
          void'(exp_wr_q.pop_front());
        end
      end
    end

    if (!dfi_init_complete_i && cmd != CMD_DESEL) begin
      protocol_error($sformatf("command %04b before init complete", cmd));
    end

    if (cmd != CMD_NOP && cmd != CMD_DESEL) begin
      if (have_last) begin
        check_gap($sformatf("gap after %s", last_cmd.name()), cycle - last_cmd_cycle,
                  last_gap, 32'hffff_ffff);
      end
      have_last      = 1'b1;
      last_cmd       = cmd;
      last_cmd_cycle = cycle;
      case (cmd)
        CMD_ACT: begin
          if (mdl_open[dfi_bank_o]) protocol_error("ACT to an open bank");
          mdl_open[dfi_bank_o] = 1'b1;
          mdl_row[dfi_bank_o]  = dfi_address_o;
          last_gap = T_RCD;
        end
        CMD_PRE: begin
          if (dfi_address_o[ADDR_BIT_ALLBANK]) begin
            foreach (mdl_open[b]) mdl_open[b] = 1'b0;
            preall_count++;
            log_cmd.delete();
            log_bank.delete();
            log_addr.delete();
          end else begin
            mdl_open[dfi_bank_o] = 1'b0;
          end
          last_gap = T_RP;
        end
        CMD_REF: begin
          if (mdl_open.or() != 1'b0) protocol_error("REF with rows still open");
          check_gap("refresh interval", cycle - last_ref_cycle, 0, REF_LIMIT);
          last_ref_cycle = cycle;
          ref_count++;
          foreach (sb_open[b]) sb_open[b] = 1'b0;
          log_cmd.delete();
          log_bank.delete();
          log_addr.delete();
          last_gap = T_RFC;
        end
        CMD_READ, CMD_WRITE: begin
          if (!mdl_open[dfi_bank_o]) protocol_error($sformatf("%s to a closed bank", cmd.name()));
          key = beat_key(dfi_bank_o, mdl_row[dfi_bank_o], col_t'(dfi_address_o));
          if (cmd == CMD_READ) begin
            for (int k = 0; k < BEATS; k++) begin
              rd_beats_q.push_back(dram.exists(key + k) ? dram[key + k] : fill_word(key + k));
            end
            rd_cycle_q.push_back(cycle);
          end else begin
            wr_key_q.push_back(key);
          end
          last_gap = (last_rw == cmd) ? T_RW_SEQ : T_RW_NONSEQ;
          last_rw  = cmd;
        end
        default: protocol_error($sformatf("unknown command %04b", cmd));
      endcase
      // commands that belong to the pending user request
      if (req_active && (cmd == CMD_ACT || cmd == CMD_READ || cmd == CMD_WRITE ||
          (cmd == CMD_PRE && !dfi_address_o[ADDR_BIT_ALLBANK]))) begin
        log_cmd.push_back(cmd);
        log_bank.push_back(dfi_bank_o);
        log_addr.push_back(dfi_address_o);
      end
    end
  end

  // ----------------------------------------
  // one request from the table
  // ----------------------------------------
  task automatic run_request(input int idx);
    cmd_t        rw;
    row_t        rw_addr;
    int unsigned waited;
    cmd_t        exp_cmd [$];
    row_t        exp_addr [$];
    row_t        exp_mask [$];
    bank_t       bank;
    row_t        row;
    bank = tab_bank[idx];
    row  = tab_row[idx];
    rw   = tab_wr[idx] ? CMD_WRITE : CMD_READ;
    rw_addr = '0;
    rw_addr[COL_W-1:0] = {tab_col[idx][COL_W-1:3], 3'b000};

    // expected sequence from the bank state seen so far
    if (sb_open[bank] && sb_row[bank] != row) begin
      exp_cmd.push_back(CMD_PRE);
      exp_addr.push_back('0);
      exp_mask.push_back(row_t'(1) << ADDR_BIT_ALLBANK);
    end
    if (!(sb_open[bank] && sb_row[bank] == row)) begin
      exp_cmd.push_back(CMD_ACT);
      exp_addr.push_back(row);
      exp_mask.push_back('1);
    end
    exp_cmd.push_back(rw);
    exp_addr.push_back(rw_addr);
    exp_mask.push_back(row_t'((1 << (ADDR_BIT_AUTOPRE + 1)) - 1));

    log_cmd.delete();
    log_bank.delete();
    log_addr.delete();
    req_active   = 1'b1;
    @(negedge clk_i);
    mem_addr_i   = make_addr(row, bank, tab_col[idx]);
    mem_wrdata_i = tab_data[idx];
    mem_rd_i     = !tab_wr[idx];
    mem_wr_i     = tab_wr[idx];

    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!mem_accept_o && waited < ACCEPT_LIMIT);

    if (!mem_accept_o) begin
      timeout_errs++;
      $display("request %0d was not accepted within %0d cycles", idx, ACCEPT_LIMIT);
      mem_rd_i   = 1'b0;
      mem_wr_i   = 1'b0;
      req_active = 1'b0;
    end else begin
      if (tab_wr[idx]) begin
        if (!mem_ack_o) protocol_error($sformatf("write %0d not acked with its accept", idx));
        exp_wr_q.push_back(tab_data[idx]);
      end
      @(negedge clk_i);
      mem_rd_i = 1'b0;
      mem_wr_i = 1'b0;
      @(posedge clk_i);
      req_active = 1'b0;

      if (log_cmd.size() != exp_cmd.size()) begin
        cmd_errs++;
        $display("[ERROR] %0t: request %0d issued %0d commands, expected %0d",
                 $time, idx, log_cmd.size(), exp_cmd.size());
      end
      for (int k = 0; k < exp_cmd.size() && k < log_cmd.size(); k++) begin
        check_cmd($sformatf("request %0d command %0d", idx, k), log_cmd[k], log_bank[k],
                  log_addr[k], exp_cmd[k], bank, exp_addr[k], exp_mask[k]);
      end
      sb_open[bank] = 1'b1;
      sb_row[bank]  = row;

      if (!tab_wr[idx]) begin
        waited = 0;
        do begin
          @(negedge clk_i);
          waited++;
        end while (!mem_ack_o && waited < ACK_LIMIT);
        if (!mem_ack_o) begin
          timeout_errs++;
          $display("read %0d got no ack within %0d cycles", idx, ACK_LIMIT);
        end else if (rd_cycle_q.size() == 0) begin
          protocol_error($sformatf("read %0d acked with no READ on the bus", idx));
        end else begin
          check_gap($sformatf("read %0d ack latency", idx), cycle - rd_cycle_q.pop_front(),
                    RD_ACK_DLY, RD_ACK_DLY);
          check_data($sformatf("read %0d data", idx), mem_rddata_o, tab_data[tab_src[idx]]);
        end
      end
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    rst_n_i             = 1'b0;
    mem_rd_i            = 1'b0;
    mem_wr_i            = 1'b0;
    mem_addr_i          = '0;
    mem_wrdata_i        = '0;
    dfi_rddata_valid_i  = 1'b0;
    dfi_rddata_i        = '0;
    dfi_init_complete_i = 1'b0;
    foreach (mdl_open[b]) begin
      mdl_open[b] = 1'b0;
      mdl_row[b]  = '0;
      sb_open[b]  = 1'b0;
      sb_row[b]   = '0;
    end
    build_table();

    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (20) @(negedge clk_i);
    dfi_init_complete_i = 1'b1;
    last_ref_cycle      = cycle;

    for (int i = 0; i < N_REQ; i++) begin
      run_request(i);
    end

    // rows stay open, so the next refresh needs precharge-all
    wait (ref_count >= 2);
    repeat (T_RFC) @(negedge clk_i);
    check_gap("refresh interval at end", cycle - last_ref_cycle, 0, REF_LIMIT);
    if (preall_count == 0) protocol_error("no precharge-all before a refresh with open rows");

    $display("errors: cmd %0d, data %0d, beat %0d, gap %0d, protocol %0d, timeout %0d",
             cmd_errs, data_errs, beat_errs, gap_errs, proto_errs, timeout_errs);
    if (cmd_errs + data_errs + beat_errs + gap_errs + proto_errs + timeout_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk_i);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/mc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_top import mc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,

  // user side
  input  logic      mem_rd_i,
  input  logic      mem_wr_i,
  input  mem_addr_t mem_addr_i,
  input  mem_data_t mem_wrdata_i,
  output mem_data_t mem_rddata_o,
  output logic      mem_accept_o,
  output logic      mem_ack_o,

  // dfi command
  output logic      dfi_cs_n_o,
  output logic      dfi_ras_n_o,
  output logic      dfi_cas_n_o,
  output logic      dfi_we_n_o,
  output bank_t     dfi_bank_o,
  output row_t      dfi_address_o,

  // dfi data
  output logic      dfi_wrdata_en_o,
  output dfi_data_t dfi_wrdata_o,
  output logic      dfi_rddata_en_o,
  input  logic      dfi_rddata_valid_i,
  input  dfi_data_t dfi_rddata_i,
  input  logic      dfi_init_complete_i
);

  bank_t req_bank;
  row_t  req_row;
  logic  act, pre_one, pre_all;
  logic  hit, bank_open, open_any;
  logic  ref_req, ref_done;
  logic  wr_push, wr_full;
  logic  issue_rd, issue_wr;
  logic  rd_ack;

  mc_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mem_rd_i      (mem_rd_i),
    .mem_wr_i      (mem_wr_i),
    .mem_addr_i    (mem_addr_i),
    .init_done_i   (dfi_init_complete_i),
    .ref_req_i     (ref_req),
    .hit_i         (hit),
    .open_i        (bank_open),
    .open_any_i    (open_any),
    .wr_full_i     (wr_full),
    .req_bank_o    (req_bank),
    .req_row_o     (req_row),
    .act_o         (act),
    .pre_one_o     (pre_one),
    .pre_all_o     (pre_all),
    .ref_done_o    (ref_done),
    .wr_push_o     (wr_push),
    .mem_accept_o  (mem_accept_o),
    .issue_rd_o    (issue_rd),
    .issue_wr_o    (issue_wr),
    .dfi_cs_n_o    (dfi_cs_n_o),
    .dfi_ras_n_o   (dfi_ras_n_o),
    .dfi_cas_n_o   (dfi_cas_n_o),
    .dfi_we_n_o    (dfi_we_n_o),
    .dfi_bank_o    (dfi_bank_o),
    .dfi_address_o (dfi_address_o)
  );

  mc_bank_table u_bank_table (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .bank_i     (req_bank),
    .row_i      (req_row),
    .act_i      (act),
    .pre_one_i  (pre_one),
    .pre_all_i  (pre_all),
    .hit_o      (hit),
    .open_o     (bank_open),
    .open_any_o (open_any)
  );

  mc_refresh_timer u_refresh_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .init_done_i (dfi_init_complete_i),
    .ref_done_i  (ref_done),
    .ref_req_o   (ref_req)
  );

  mc_rd_path u_rd_path (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .issue_rd_i         (issue_rd),
    .dfi_rddata_valid_i (dfi_rddata_valid_i),
    .dfi_rddata_i       (dfi_rddata_i),
    .dfi_rddata_en_o    (dfi_rddata_en_o),
    .rd_ack_o           (rd_ack),
    .mem_rddata_o       (mem_rddata_o)
  );

  mc_wr_path u_wr_path (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .issue_wr_i      (issue_wr),
    .wr_push_i       (wr_push),
    .mem_wrdata_i    (mem_wrdata_i),
    .wr_full_o       (wr_full),
    .dfi_wrdata_en_o (dfi_wrdata_en_o),
    .dfi_wrdata_o    (dfi_wrdata_o)
  );

  // writes are acked on accept, reads when the word is joined
  assign mem_ack_o = wr_push | rd_ack;

endmodule

`default_nettype wire

/* rtl/mc_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_ctrl import mc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      mem_rd_i,
  input  logic      mem_wr_i,
  input  mem_addr_t mem_addr_i,
  input  logic      init_done_i,
  input  logic      ref_req_i,
  input  logic      hit_i,
  input  logic      open_i,
  input  logic      open_any_i,
  input  logic      wr_full_i,
  output bank_t     req_bank_o,
  output row_t      req_row_o,
  output logic      act_o,
  output logic      pre_one_o,
  output logic      pre_all_o,
  output logic      ref_done_o,
  output logic      wr_push_o,
  output logic      mem_accept_o,
  output logic      issue_rd_o,
  output logic      issue_wr_o,
  output logic      dfi_cs_n_o,
  output logic      dfi_ras_n_o,
  output logic      dfi_cas_n_o,
  output logic      dfi_we_n_o,
  output bank_t     dfi_bank_o,
  output row_t      dfi_address_o
);

  // ----------------------------------------
  // address split, row | bank | col
  // ----------------------------------------
  localparam int COL_W  = $bits(col_t);
  localparam int BANK_W = $bits(bank_t);

  col_t req_col;

  assign req_col    = mem_addr_i[COL_W-1:0];
  assign req_bank_o = mem_addr_i[COL_W +: BANK_W];
  assign req_row_o  = mem_addr_i[COL_W+BANK_W +: $bits(row_t)];

  // ----------------------------------------
  // request FSM
  // ----------------------------------------
  ctrl_state_t state_q, state_d;
  ctrl_state_t target_q, target_d;
  ctrl_state_t rw_state;
  cmd_t        cmd_d, cmd_q, last_rw_q;
  bank_t       bank_d, bank_q;
  row_t        addr_d, addr_q;
  logic [DLY_W-1:0] gap_q, gap_sel;
  logic        gap_ok;

  assign gap_ok   = (gap_q == '0);
  assign rw_state = mem_rd_i ? ST_READ : ST_WRITE;

  always_comb begin
    state_d  = state_q;
    target_d = target_q;
    cmd_d    = CMD_NOP;
    bank_d   = '0;
    addr_d   = '0;
    case (state_q)
      ST_INIT: begin
        if (ref_req_i) state_d = ST_REF;
      end
      ST_IDLE: begin
        // refresh wins over user requests
        if (ref_req_i) begin
          state_d  = open_any_i ? ST_PRE : ST_REF;
          target_d = ST_REF;
        end else if (mem_rd_i || mem_wr_i) begin
          target_d = rw_state;
          if (hit_i) state_d = rw_state;
          else if (open_i) state_d = ST_PRE;
          else state_d = ST_ACT;
        end
      end
      ST_PRE: begin
        if (gap_ok) begin
          cmd_d = CMD_PRE;
          if (target_q == ST_REF) begin
            addr_d[ADDR_BIT_ALLBANK] = 1'b1;
            state_d = ST_REF;
          end else begin
            bank_d  = req_bank_o;
            state_d = ST_ACT;
          end
        end
      end
      ST_ACT: begin
        if (gap_ok) begin
          cmd_d   = CMD_ACT;
          bank_d  = req_bank_o;
          addr_d  = req_row_o;
          state_d = target_q;
        end
      end
      ST_READ, ST_WRITE: begin
        // writes also wait for room in the write buffer
        if (gap_ok && (state_q == ST_READ || !wr_full_i)) begin
          cmd_d  = (state_q == ST_READ) ? CMD_READ : CMD_WRITE;
          bank_d = req_bank_o;
          addr_d[COL_W-1:0] = {req_col[COL_W-1:3], 3'b000};
          addr_d[ADDR_BIT_AUTOPRE] = 1'b0;
          state_d = ST_IDLE;
        end
      end
      ST_REF: begin
        if (gap_ok) begin
          cmd_d   = CMD_REF;
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_INIT;
      target_q <= ST_IDLE;
    end else begin
      state_q  <= state_d;
      target_q <= target_d;
    end
  end

  // ----------------------------------------
  // command gap timer
  // ----------------------------------------
  always_comb begin
    case (cmd_d)
      CMD_ACT:   gap_sel = DLY_W'(T_RCD);
      CMD_PRE:   gap_sel = DLY_W'(T_RP);
      CMD_REF:   gap_sel = DLY_W'(T_RFC);
      CMD_READ:  gap_sel = (last_rw_q == CMD_READ) ? DLY_W'(T_RW_SEQ) : DLY_W'(T_RW_NONSEQ);
      CMD_WRITE: gap_sel = (last_rw_q == CMD_WRITE) ? DLY_W'(T_RW_SEQ) : DLY_W'(T_RW_NONSEQ);
      default:   gap_sel = DLY_W'(1);
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gap_q     <= '0;
      last_rw_q <= CMD_NOP;
    end else begin
      if (cmd_d != CMD_NOP) gap_q <= gap_sel - 1'b1;
      else if (!gap_ok) gap_q <= gap_q - 1'b1;
      if (cmd_d == CMD_READ || cmd_d == CMD_WRITE) last_rw_q <= cmd_d;
    end
  end

  // ----------------------------------------
  // registered DFI command
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_q      <= CMD_DESEL;
      bank_q     <= '0;
      addr_q     <= '0;
      issue_rd_o <= 1'b0;
      issue_wr_o <= 1'b0;
    end else begin
      cmd_q      <= init_done_i ? cmd_d : CMD_DESEL;
      bank_q     <= bank_d;
      addr_q     <= addr_d;
      issue_rd_o <= (cmd_d == CMD_READ);
      issue_wr_o <= (cmd_d == CMD_WRITE);
    end
  end

  assign {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} = cmd_q;
  assign dfi_bank_o    = bank_q;
  assign dfi_address_o = addr_q;

  // strobes to the bank table, refresh timer and write path
  assign act_o        = (cmd_d == CMD_ACT);
  assign pre_all_o    = (cmd_d == CMD_PRE) && addr_d[ADDR_BIT_ALLBANK];
  assign pre_one_o    = (cmd_d == CMD_PRE) && !addr_d[ADDR_BIT_ALLBANK];
  assign ref_done_o   = (cmd_d == CMD_REF);
  assign wr_push_o    = (cmd_d == CMD_WRITE);
  assign mem_accept_o = (cmd_d == CMD_READ) || (cmd_d == CMD_WRITE);

  // bus stays quiet while the gap timer runs
  a_gap_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gap_q != '0) |=> (cmd_q inside {CMD_NOP, CMD_DESEL}));

endmodule

`default_nettype wire

/* rtl/mc_wr_path.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_wr_path import mc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      issue_wr_i,
  input  logic      wr_push_i,
  input  mem_data_t mem_wrdata_i,
  output logic      wr_full_o,
  output logic      dfi_wrdata_en_o,
  output dfi_data_t dfi_wrdata_o
);

  // bit k is set k+1 cycles after WRITE reached the bus
  logic [WR_POP_DLY-2:0]  wr_sr_q;
  beat_idx_t              beat_q;
  mem_data_t              head;
  dfi_data_t [BEATS-1:0]  head_beats;
  logic                   wr_pop;

  mc_wr_fifo u_wr_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (wr_push_i),
    .push_data_i (mem_wrdata_i),
    .pop_i       (wr_pop),
    .full_o      (wr_full_o),
    .head_o      (head)
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_sr_q <= '0;
    end else begin
      wr_sr_q <= {wr_sr_q[WR_POP_DLY-3:0], issue_wr_i};
    end
  end

  // ----------------------------------------
  // enable window and beat split
  // ----------------------------------------
  assign dfi_wrdata_en_o = |wr_sr_q[N_PHY_WRLAT+BEATS-2:N_PHY_WRLAT-1];

  // wraps after the last beat, ready for a back-to-back write
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      beat_q <= '0;
    end else if (dfi_wrdata_en_o) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  assign head_beats   = head;
  assign dfi_wrdata_o = head_beats[beat_q];

  // head advances during the last beat
  assign wr_pop = wr_sr_q[WR_POP_DLY-2];

endmodule

`default_nettype wire

/* rtl/mc_rd_path.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_rd_path import mc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      issue_rd_i,
  input  logic      dfi_rddata_valid_i,
  input  dfi_data_t dfi_rddata_i,
  output logic      dfi_rddata_en_o,
  output logic      rd_ack_o,
  output mem_data_t mem_rddata_o
);

  localparam int BEAT_W = $bits(dfi_data_t);

  // bit k is set k+1 cycles after READ reached the bus
  logic [RD_ACK_DLY-1:0] rd_sr_q;
  mem_data_t             rd_word_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_sr_q <= '0;
    end else begin
      rd_sr_q <= {rd_sr_q[RD_ACK_DLY-2:0], issue_rd_i};
    end
  end

  // enable window of BEATS cycles, N_RDDATA_EN after READ
  assign dfi_rddata_en_o = |rd_sr_q[N_RDDATA_EN+BEATS-2:N_RDDATA_EN-1];
  assign rd_ack_o        = rd_sr_q[RD_ACK_DLY-1];

  // beats enter at the top, beat 0 ends up in the low word
  always_ff @(posedge clk_i) begin
    if (dfi_rddata_valid_i) begin
      rd_word_q <= {dfi_rddata_i, rd_word_q[$bits(mem_data_t)-1:BEAT_W]};
    end
  end

  assign mem_rddata_o = rd_word_q;

endmodule

`default_nettype wire

/* rtl/mc_refresh_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_refresh_timer import mc_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic init_done_i,
  input  logic ref_done_i,
  output logic ref_req_o
);

  logic [REF_CNT_W-1:0] cnt_q;
  logic                 expired;

  assign expired = (cnt_q == '0);

  // init wait first, then the periodic interval
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= REF_CNT_W'(INIT_WAIT_C);
    end else if (!init_done_i) begin
      cnt_q <= REF_CNT_W'(INIT_WAIT_C);
    end else if (expired) begin
      cnt_q <= REF_CNT_W'(REF_INTERVAL_C);
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // held until the REF goes out
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ref_req_o <= 1'b0;
    end else if (init_done_i && expired) begin
      ref_req_o <= 1'b1;
    end else if (ref_done_i) begin
      ref_req_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rtl/mc_bank_table.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_bank_table import mc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  bank_t bank_i,
  input  row_t  row_i,
  input  logic  act_i,
  input  logic  pre_one_i,
  input  logic  pre_all_i,
  output logic  hit_o,
  output logic  open_o,
  output logic  open_any_o
);

  logic [N_BANKS-1:0] open_q;
  row_t               row_q [N_BANKS];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      open_q <= '0;
    end else if (pre_all_i) begin
      open_q <= '0;
    end else if (pre_one_i) begin
      open_q[bank_i] <= 1'b0;
    end else if (act_i) begin
      open_q[bank_i] <= 1'b1;
    end
  end

  // row only matters while the open flag is set
  always_ff @(posedge clk_i) begin
    if (act_i) row_q[bank_i] <= row_i;
  end

  assign open_o     = open_q[bank_i];
  assign hit_o      = open_q[bank_i] && (row_q[bank_i] == row_i);
  assign open_any_o = |open_q;

  a_act_closed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    act_i |-> !open_q[bank_i]);

endmodule

`default_nettype wire

/* rtl/mc_wr_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module mc_wr_fifo import mc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      push_i,
  input  mem_data_t push_data_i,
  input  logic      pop_i,
  output logic      full_o,
  output mem_data_t head_o
);

  mem_data_t  mem_q [4];
  logic [1:0] wr_ptr_q, rd_ptr_q;
  logic [2:0] count_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      // push and pop together leave the count alone
      if (push_i && !pop_i) count_q <= count_q + 1'b1;
      else if (pop_i && !push_i) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= push_data_i;
  end

  assign full_o = (count_q == 3'd4);
  assign head_o = mem_q[rd_ptr_q];

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> (count_q != '0));

endmodule

`default_nettype wire

/* rtl/mc_pkg.sv */
`default_nettype none

package mc_pkg;

  // ----------------------------------------
  // address and data widths
  // ----------------------------------------
  typedef logic [2:0]   bank_t;
  typedef logic [14:0]  row_t;
  typedef logic [9:0]   col_t;
  typedef logic [27:0]  mem_addr_t;
  typedef logic [127:0] mem_data_t;
  typedef logic [31:0]  dfi_data_t;
  typedef logic [1:0]   beat_idx_t;

  localparam int N_BANKS          = 8;
  localparam int BEATS            = 4;
  localparam int ADDR_BIT_ALLBANK = 10;
  localparam int ADDR_BIT_AUTOPRE = 10;

  // ----------------------------------------
  // timing, in controller cycles
  // ----------------------------------------
  localparam int T_RCD       = 4;
  localparam int T_RP        = 4;
  localparam int T_RFC       = 20;
  localparam int T_RW_SEQ    = 4;
  localparam int T_RW_NONSEQ = 6;

  localparam int REF_INTERVAL_C = 600;
  localparam int INIT_WAIT_C    = 50;
  localparam int REF_CNT_W      = $clog2(REF_INTERVAL_C + 1);

  // phy latencies seen from the registered command
  localparam int N_RDDATA_EN = 3;
  localparam int N_PHY_WRLAT = 3;
  localparam int RD_ACK_DLY  = N_RDDATA_EN + 5;
  localparam int WR_POP_DLY  = N_PHY_WRLAT + BEATS;

  localparam int DLY_W = 6;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP   = 4'b0111,
    CMD_ACT   = 4'b0011,
    CMD_PRE   = 4'b0010,
    CMD_READ  = 4'b0101,
    CMD_WRITE = 4'b0100,
    CMD_REF   = 4'b0001,
    CMD_DESEL = 4'b1111
  } cmd_t;

  typedef enum logic [2:0] {
    ST_INIT,
    ST_IDLE,
    ST_PRE,
    ST_ACT,
    ST_READ,
    ST_WRITE,
    ST_REF
  } ctrl_state_t;

endpackage

`default_nettype wire
